/* all.f */
+incdir+include
source/fpu_pkg.sv
source/fpu_apb_regs.sv
source/fpu_mul_unpack.sv
source/fpu_mul_core.sv
source/fpu_round.sv
source/fpu_exceptions.sv
source/fpu_top.sv
test/tb_fpu_top.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_fpu_top
BUILD_DIR ?= build
SEED_ARGS ?=
VFLAGS    ?= --binary --timing -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) $(SEED_ARGS) --top-module $(TOP) -Mdir $(BUILD_DIR) \
		-f all.f -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

/* test/tb_fpu_top.sv */
`timescale 1ns/100ps
`include "fpu_cfg.svh"

module tb_fpu_top #(
	parameter logic [31:0] SEED = 32'hca8
);
	import fpu_pkg::*;

	logic        clk;
	logic        rst;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [7:0]  paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic        pready;
	logic        pslverr;

	logic [31:0] rng;
	fp64_t       cur_a;
	fp64_t       cur_b;
	fp64_t       exp_vals[$];
	flags_t      exp_flags[$];
	int          n_checked;

	fpu_top i_dut (
		.clk     (clk),
		.rst     (rst),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.paddr   (paddr),
		.pwdata  (pwdata),
		.prdata  (prdata),
		.pready  (pready),
		.pslverr (pslverr)
	);

	initial clk = 1'b0;
	always #2 clk = ~clk;

	// ********************
	// random numbers and failure handling

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic rand32(output logic [31:0] r);
		rng = xorshift(rng);
		r = rng;
	endtask

	task automatic stop_run(input string line);
		$display("%s", line);
		$display("Done: errors found");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_value(input fp64_t got, input fp64_t want, input string what);
		if (got !== want)
			stop_run($sformatf("[ERROR] %0t: %s value %h, expected %h", $time, what, got, want));
	endtask

	task automatic check_flags(input flags_t got, input flags_t want, input string what);
		if (got !== want)
			stop_run($sformatf("[ERROR] %0t: %s flags %b, expected %b", $time, what, got, want));
	endtask

	task automatic check_bit(input logic got, input logic want, input string what);
		if (got !== want)
			stop_run($sformatf("[ERROR] %0t: %s is %b, expected %b", $time, what, got, want));
	endtask

	task automatic check_word(input logic [31:0] got, input logic [31:0] want, input string what);
		if (got !== want)
			stop_run($sformatf("[ERROR] %0t: %s read %h, expected %h", $time, what, got, want));
	endtask

	// ********************
	// apb transfers

	task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, output logic err);
		@(posedge clk);
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= 1'b1;
		paddr   <= addr;
		pwdata  <= data;
		@(posedge clk);
		penable <= 1'b1;
		@(negedge clk);   // access phase, zero wait states
		err = pslverr;
		@(posedge clk);
		psel    <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output logic err);
		@(posedge clk);
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= 1'b0;
		paddr   <= addr;
		@(posedge clk);
		penable <= 1'b1;
		@(negedge clk);
		data = prdata;
		err  = pslverr;
		check_bit(pready, 1'b1, "pready");
		@(posedge clk);
		psel    <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic read_expect(input logic [7:0] addr, input logic [31:0] want, input string what);
		logic [31:0] word;
		logic        err;
		apb_read(addr, word, err);
		check_bit(err, 1'b0, "pslverr on register read");
		check_word(word, want, what);
	endtask

	// ********************
	// reference model

	task automatic model(input fp64_t a, input fp64_t b, input rmode_t rm,
	                     output fp64_t val, output flags_t fl);
		int           ea;
		int           eb;
		int           e;
		logic [51:0]  fa;
		logic [51:0]  fb;
		logic [51:0]  frac;
		logic         sg, za, zb, ia, ib, na, nb, sa, sb, g, s, up;
		logic [105:0] p;
		logic [53:0]  m;
		ea = {21'b0, a[62:52]};
		eb = {21'b0, b[62:52]};
		fa = a[51:0];
		fb = b[51:0];
		sg = a[63] ^ b[63];
		za = (ea == 0);   // subnormals count as zero
		zb = (eb == 0);
		ia = (ea == 2047) && (fa == '0);
		ib = (eb == 2047) && (fb == '0);
		sa = (ea == 2047) && (fa != '0) && !fa[51];
		sb = (eb == 2047) && (fb != '0) && !fb[51];
		na = (ea == 2047) && (fa != '0);
		nb = (eb == 2047) && (fb != '0);
		fl = '0;
		val = '0;
		if (na || nb) begin
			val = na ? (a | 64'h0008_0000_0000_0000) : (b | 64'h0008_0000_0000_0000);
			fl.invalid = sa | sb;
		end else if ((za && ib) || (ia && zb)) begin
			val = {sg, 11'h7ff, 1'b1, 51'b0};
			fl.invalid = 1'b1;
		end else if (ia || ib) begin
			val = {sg, 11'h7ff, 52'b0};
		end else if (za || zb) begin
			val = {sg, 63'b0};
		end else begin
			p = {53'b0, 1'b1, fa} * {53'b0, 1'b1, fb};
			e = ea + eb - 1023;
			if (p[105]) begin
				frac = p[104:53];
				g    = p[52];
				s    = |p[51:0];
				e    = e + 1;
			end else begin
				frac = p[103:52];
				g    = p[51];
				s    = |p[50:0];
			end
			case (rm)
				2'd0:    up = g & (s | frac[0]);
				2'd1:    up = 1'b0;
				2'd2:    up = !sg & (g | s);
				default: up = sg & (g | s);
			endcase
			m = {2'b01, frac} + {53'b0, up};
			if (m[53]) begin
				frac = m[52:1];
				e    = e + 1;
			end else begin
				frac = m[51:0];
			end
			if (e > 2046) begin
				fl.overflow = 1'b1;
				fl.inexact  = 1'b1;
				if (rm == 2'd1 || (rm == 2'd2 && sg) || (rm == 2'd3 && !sg))
					val = {sg, 11'h7fe, {52{1'b1}}};
				else
					val = {sg, 11'h7ff, 52'b0};
			end else if (e < 1) begin
				fl.underflow = 1'b1;
				fl.inexact   = 1'b1;
				val = {sg, 63'b0};
			end else begin
				val = {sg, e[10:0], frac};
				fl.inexact = g | s;
			end
		end
		fl.exception = fl.invalid | fl.overflow | fl.underflow | fl.inexact;
	endtask

	// ********************
	// operands and operations

	task automatic make_normal(input int lo, input int span, output fp64_t v);
		logic [31:0] r0, r1, r2;
		int          e;
		rand32(r0);
		rand32(r1);
		rand32(r2);
		e = lo + (int'(r2[15:0]) % span);
		v = {r2[31], e[10:0], r0[19:0], r1};
	endtask

	task automatic make_special(input int kind, output fp64_t v);
		logic [31:0] r0, r1;
		rand32(r0);
		rand32(r1);
		case (kind)
			0:       make_normal(1, 2046, v);
			1:       v = {r0[31], 63'b0};
			2:       v = {r0[31], 11'h7ff, 52'b0};
			3:       v = {r0[31], 11'h7ff, 1'b1, r0[18:0], r1};   // quiet nan
			4:       v = {r0[31], 11'h7ff, 2'b01, r0[17:0], r1};  // signaling nan
			default: v = {r0[31], 11'h000, r0[19:0], r1};         // subnormal, flushed
		endcase
	endtask

	task automatic write_ok(input logic [7:0] addr, input logic [31:0] data);
		logic err;
		apb_write(addr, data, err);
		check_bit(err, 1'b0, "pslverr on operand write");
	endtask

	task automatic set_operands(input fp64_t a, input fp64_t b);
		write_ok(`FPU_REG_OPA_LO, a[31:0]);
		write_ok(`FPU_REG_OPA_HI, a[63:32]);
		write_ok(`FPU_REG_OPB_LO, b[31:0]);
		write_ok(`FPU_REG_OPB_HI, b[63:32]);
		cur_a = a;
		cur_b = b;
	endtask

	task automatic start(input rmode_t rm, input logic refused);
		logic   err;
		fp64_t  v;
		flags_t f;
		apb_write(`FPU_REG_CTRL, {30'b0, rm}, err);
		check_bit(err, refused, "pslverr on CTRL write");
		if (!refused) begin
			model(cur_a, cur_b, rm, v, f);
			exp_vals.push_back(v);
			exp_flags.push_back(f);
		end
	endtask

	task automatic wait_results(input int n);
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (int'(i_dut.i_regs.fifo_cnt) < n) begin
			cycles++;
			if (cycles > 4 * `FPU_PIPE_DEPTH)   // pipeline latency with margin
				stop_run("Timeout: the result FIFO did not receive the expected results");
			@(negedge clk);
		end
	endtask

	task automatic fetch_check(input string what);
		logic [31:0] lo, hi, fw;
		logic        err;
		fp64_t       want_v;
		flags_t      want_f;
		apb_read(`FPU_REG_RES_LO, lo, err);
		check_bit(err, 1'b0, "pslverr on RES_LO read");
		apb_read(`FPU_REG_RES_HI, hi, err);
		check_bit(err, 1'b0, "pslverr on RES_HI read");
		apb_read(`FPU_REG_FLAGS, fw, err);   // pops the entry
		check_bit(err, 1'b0, "pslverr on FLAGS read");
		check_bit(fw[8], 1'b1, "FLAGS not empty bit");
		want_v = exp_vals.pop_front();
		want_f = exp_flags.pop_front();
		check_value(fp64_t'({hi, lo}), want_v, what);
		check_flags(flags_t'(fw[4:0]), want_f, what);
		n_checked++;
	endtask

	task automatic run_one(input fp64_t a, input fp64_t b, input rmode_t rm, input string what);
		set_operands(a, b);
		start(rm, 1'b0);
		wait_results(1);
		fetch_check(what);
	endtask

	// ********************
	// test sequence

	initial begin
		logic [31:0] r;
		logic [31:0] word;
		logic        err;
		fp64_t       a;
		fp64_t       b;
		int          i;
		rng       = SEED;
		n_checked = 0;
		rst     <= 1'b1;
		psel    <= 1'b0;
		penable <= 1'b0;
		pwrite  <= 1'b0;
		paddr   <= '0;
		pwdata  <= '0;
		repeat (4) @(posedge clk);
		rst <= 1'b0;

		apb_read(`FPU_REG_FLAGS, word, err);
		check_bit(err, 1'b0, "pslverr on empty FLAGS read");
		check_word(word, 32'h0, "FLAGS on empty FIFO");
		apb_read(8'h20, word, err);
		check_bit(err, 1'b1, "pslverr on unmapped read");
		apb_write(8'h24, 32'h1, err);
		check_bit(err, 1'b1, "pslverr on unmapped write");
		apb_read(8'h02, word, err);
		check_bit(err, 1'b1, "pslverr on unaligned read");

		for (i = 0; i < 200; i++) begin
			make_normal(900, 247, a);
			make_normal(900, 247, b);
			run_one(a, b, rmode_t'(i % 4), "normal product");
		end

		// 1.5 times (1 + k ulp) lands exactly halfway for odd k
		for (i = 0; i < 8; i++) begin
			run_one({i[2], 63'h3ff8_0000_0000_0000}, 64'h3ff0_0000_0000_0001, rmode_t'(i[1:0]),
			        "halfway, odd fraction");
			run_one(64'h3ff8_0000_0000_0000, {i[2], 63'h3ff0_0000_0000_0003}, rmode_t'(i[1:0]),
			        "halfway, even fraction");
			run_one({i[2], 63'h3ff8_0000_0000_0000}, 64'h4000_0000_0000_0000, rmode_t'(i[1:0]),
			        "exact product");
		end

		// exponent sums straddling the overflow and underflow limits
		for (i = 0; i < 160; i++) begin
			rand32(r);
			if (i < 80) begin
				make_normal(1522, 26, a);
				make_normal(1522, 26, b);
			end else begin
				make_normal(500, 26, a);
				make_normal(500, 26, b);
			end
			run_one(a, b, rmode_t'(r[1:0]), "range edge");
		end
		for (i = 0; i < 8; i++) begin
			run_one({i[2], 11'h7fe, {52{1'b1}}}, 64'h3ff0_0000_0000_0001, rmode_t'(i[1:0]),
			        "largest finite");
			run_one({i[2], 63'h0010_0000_0000_0000}, 64'h3fef_ffff_ffff_ffff, rmode_t'(i[1:0]),
			        "smallest normal");
		end

		for (i = 0; i < 200; i++) begin
			rand32(r);
			make_special(int'(r[7:0]) % 6, a);
			make_special(int'(r[15:8]) % 6, b);
			run_one(a, b, rmode_t'(r[17:16]), "special operand");
		end
		run_one(64'h7ff8_0000_0000_1234, 64'hfff0_0000_0000_0001, 2'd0, "qnan before snan");
		run_one(64'hfff0_0000_0000_00ab, 64'h7ff8_0000_0000_0055, 2'd1, "snan in opa");
		run_one(64'h8000_0000_0000_0000, 64'h7ff0_0000_0000_0000, 2'd2, "zero times inf");
		run_one(64'hfff0_0000_0000_0000, 64'hc000_0000_0000_0000, 2'd3, "inf times finite");

		// fill the pipeline and FIFO, then one launch too many
		make_normal(1000, 40, a);
		make_normal(1000, 40, b);
		set_operands(a, b);
		read_expect(`FPU_REG_OPA_LO, a[31:0], "OPA_LO readback");
		read_expect(`FPU_REG_OPA_HI, a[63:32], "OPA_HI readback");
		read_expect(`FPU_REG_OPB_LO, b[31:0], "OPB_LO readback");
		read_expect(`FPU_REG_OPB_HI, b[63:32], "OPB_HI readback");
		for (i = 0; i < `FPU_FIFO_DEPTH; i++)
			start(rmode_t'(i % 4), 1'b0);
		read_expect(`FPU_REG_CTRL, 32'd3, "CTRL readback");   // last launch used mode 3
		start(2'd0, 1'b1);
		wait_results(`FPU_FIFO_DEPTH);
		for (i = 0; i < `FPU_FIFO_DEPTH; i++)
			fetch_check("back to back launch");
		apb_read(`FPU_REG_FLAGS, word, err);
		check_word(word, 32'h0, "FLAGS after drain");
		run_one(a, b, 2'd2, "launch after drain");

		$display("%0d results checked", n_checked);
		$display("Done: no errors");
		$finish;
	end

endmodule

/* source/fpu_top.sv */
`timescale 1ns/100ps

module fpu_top (
	input  logic        clk,
	input  logic        rst,
	input  logic        psel,
	input  logic        penable,
	input  logic        pwrite,
	input  logic [7:0]  paddr,
	input  logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic        pready,
	output logic        pslverr
);
	import fpu_pkg::*;

	op_req_t   req;
	unpacked_t unp;
	product_t  prd;
	rounded_t  rnd;
	result_t   res;

	// ********************
	// register block and pipeline

	fpu_apb_regs i_regs (
		.clk     (clk),
		.rst     (rst),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.paddr   (paddr),
		.pwdata  (pwdata),
		.prdata  (prdata),
		.pready  (pready),
		.pslverr (pslverr),
		.req     (req),
		.res     (res)
	);

	fpu_mul_unpack i_unpack (.clk(clk), .rst(rst), .req(req), .unp(unp));
	fpu_mul_core   i_core   (.clk(clk), .rst(rst), .unp(unp), .prd(prd));
	fpu_round      i_round  (.clk(clk), .rst(rst), .prd(prd), .rnd(rnd));
	fpu_exceptions i_except (.clk(clk), .rst(rst), .rnd(rnd), .res(res));   // two levels

endmodule

/* source/fpu_exceptions.sv */
`timescale 1ns/100ps

module fpu_exceptions (
	input  logic               clk,
	input  logic               rst,
	input  fpu_pkg::rounded_t  rnd,
	output fpu_pkg::result_t   res
);
	import fpu_pkg::*;

	class_t ca, cb;
	logic   nan_a, nan_b, special;

	// first level
	logic   v1;
	rmode_t rmode1;
	fp64_t  value1, opa1, opb1;
	logic   nan_in1, snan_in1, a_nan1, mul_0_by_inf1;
	logic   inf_out1, range_ovf1, zero_out1, uf1, lost1;

	// second level
	result_t nxt;
	logic    sign, round_down, nan_out;

	assign ca      = rnd.class_a;
	assign cb      = rnd.class_b;
	assign nan_a   = ca.is_qnan | ca.is_snan;
	assign nan_b   = cb.is_qnan | cb.is_snan;
	assign special = nan_a | nan_b | ca.is_inf | cb.is_inf | ca.is_zero | cb.is_zero;

	// ********************
	// triggers

	always_ff @(posedge clk) begin
		v1            <= rnd.valid;
		rmode1        <= rnd.rmode;
		value1        <= rnd.value;
		opa1          <= rnd.opa;
		opb1          <= rnd.opb;
		nan_in1       <= nan_a | nan_b;
		snan_in1      <= ca.is_snan | cb.is_snan;
		a_nan1        <= nan_a;
		mul_0_by_inf1 <= (ca.is_zero & cb.is_inf) | (ca.is_inf & cb.is_zero);
		inf_out1      <= (ca.is_inf & ~cb.is_zero & ~nan_b) |
		                 (cb.is_inf & ~ca.is_zero & ~nan_a) |
		                 ((rnd.exp_in > 13'sd2046) & ~special);
		range_ovf1    <= (rnd.exp_in > 13'sd2046) & ~special;
		zero_out1     <= ca.is_zero | cb.is_zero | (rnd.exp_in < 13'sd1);
		uf1           <= (rnd.exp_in < 13'sd1) & ~special;
		lost1         <= |rnd.lost;
		if (rst)
			v1 <= 1'b0;
	end

	// ********************
	// value select and flags

	assign sign       = value1[63];
	assign nan_out    = nan_in1 | mul_0_by_inf1;
	assign round_down = (rmode1 == 2'd1) | ((rmode1 == 2'd2) & sign) |
	                    ((rmode1 == 2'd3) & ~sign);

	always_comb begin
		nxt.valid = v1;
		if (nan_out) begin
			if (mul_0_by_inf1)
				nxt.value = {sign, 11'h7ff, 1'b1, 51'b0};   // default qnan
			else if (a_nan1)
				nxt.value = {opa1[63], 11'h7ff, 1'b1, opa1[50:0]};
			else
				nxt.value = {opb1[63], 11'h7ff, 1'b1, opb1[50:0]};
		end else if (inf_out1) begin
			if (range_ovf1 & round_down)
				nxt.value = {sign, 11'h7fe, {52{1'b1}}};   // largest finite
			else
				nxt.value = {sign, 11'h7ff, 52'b0};
		end else if (zero_out1) begin
			nxt.value = {sign, 63'b0};
		end else begin
			nxt.value = value1;
		end

		nxt.flags.invalid   = snan_in1 | mul_0_by_inf1;
		nxt.flags.overflow  = range_ovf1 & ~nan_in1;
		nxt.flags.underflow = uf1;
		nxt.flags.inexact   = (lost1 | range_ovf1 | uf1) & ~nan_in1;
		nxt.flags.exception = nxt.flags.invalid | nxt.flags.overflow |
		                      nxt.flags.underflow | nxt.flags.inexact;
	end

	always_ff @(posedge clk) begin
		res <= nxt;
		if (rst)
			res.valid <= 1'b0;
	end

endmodule

/* source/fpu_round.sv */
`timescale 1ns/100ps

module fpu_round (
	input  logic               clk,
	input  logic               rst,
	input  fpu_pkg::product_t  prd,
	output fpu_pkg::rounded_t  rnd
);
	import fpu_pkg::*;

	rounded_t nxt;
	logic [51:0] frac;
	logic [51:0] frac_r;
	logic        guard;
	logic        sticky;
	logic        up;
	logic [53:0] mant_r;
	exp_t        exp_n;
	exp_t        exp_r;

	// ********************
	// normalize

	always_comb begin
		if (prd.prod[105]) begin
			frac   = prd.prod[104:53];
			guard  = prd.prod[52];
			sticky = |prd.prod[51:0];
			exp_n  = prd.exp + 13'sd1;
		end else begin
			frac   = prd.prod[103:52];
			guard  = prd.prod[51];
			sticky = |prd.prod[50:0];
			exp_n  = prd.exp;
		end
	end

	// ********************
	// round by mode

	always_comb begin
		case (prd.rmode)
			2'd0:    up = guard & (sticky | frac[0]);   // ties to even
			2'd1:    up = 1'b0;
			2'd2:    up = ~prd.sign & (guard | sticky);
			default: up = prd.sign & (guard | sticky);
		endcase

		mant_r = {2'b01, frac} + 54'(up);
		if (mant_r[53]) begin   // carried into a new leading bit
			frac_r = mant_r[52:1];
			exp_r  = exp_n + 13'sd1;
		end else begin
			frac_r = mant_r[51:0];
			exp_r  = exp_n;
		end
	end

	always_comb begin
		nxt.valid   = prd.valid;
		nxt.rmode   = prd.rmode;
		nxt.value   = {prd.sign, exp_r[10:0], frac_r};   // only meaningful in range
		nxt.exp_in  = exp_r;
		nxt.lost    = {guard, sticky};
		nxt.opa     = prd.opa;
		nxt.opb     = prd.opb;
		nxt.class_a = prd.class_a;
		nxt.class_b = prd.class_b;
	end

	always_ff @(posedge clk) begin
		rnd <= nxt;
		if (rst)
			rnd.valid <= 1'b0;
	end

endmodule

/* source/fpu_mul_core.sv */
`timescale 1ns/100ps

module fpu_mul_core (
	input  logic                clk,
	input  logic                rst,
	input  fpu_pkg::unpacked_t  unp,
	output fpu_pkg::product_t   prd
);
	import fpu_pkg::*;

	localparam exp_t BIAS = 13'sd1023;

	product_t nxt;

	// ********************
	// sign, exponent, mantissa product

	always_comb begin
		nxt.valid   = unp.valid;
		nxt.rmode   = unp.rmode;
		nxt.sign    = unp.sign[1] ^ unp.sign[0];
		nxt.exp     = unp.exp_a + unp.exp_b - BIAS;   // may leave 1..2046
		nxt.prod    = prod_t'(unp.mant_a) * prod_t'(unp.mant_b);
		nxt.opa     = unp.opa;
		nxt.opb     = unp.opb;
		nxt.class_a = unp.class_a;
		nxt.class_b = unp.class_b;
	end

	always_ff @(posedge clk) begin
		prd <= nxt;
		if (rst)
			prd.valid <= 1'b0;
	end

endmodule

/* source/fpu_mul_unpack.sv */
`timescale 1ns/100ps

module fpu_mul_unpack (
	input  logic                clk,
	input  logic                rst,
	input  fpu_pkg::op_req_t    req,
	output fpu_pkg::unpacked_t  unp
);
	import fpu_pkg::*;

	unpacked_t nxt;
	logic [10:0] ea, eb;
	logic [51:0] fa, fb;
	logic a_max, b_max;

	assign ea = req.opa[62:52];
	assign eb = req.opb[62:52];
	assign fa = req.opa[51:0];
	assign fb = req.opb[51:0];
	assign a_max = (ea == 11'h7ff);
	assign b_max = (eb == 11'h7ff);

	always_comb begin
		nxt.valid = req.valid;
		nxt.rmode = req.rmode;
		nxt.opa   = req.opa;   // kept for nan payloads
		nxt.opb   = req.opb;
		nxt.sign  = {req.opa[63], req.opb[63]};
		nxt.exp_a = exp_t'({2'b00, ea});
		nxt.exp_b = exp_t'({2'b00, eb});

		// zero exponent flushes subnormals
		nxt.mant_a = (ea == '0) ? '0 : {1'b1, fa};
		nxt.mant_b = (eb == '0) ? '0 : {1'b1, fb};

		nxt.class_a.is_zero = (ea == '0);
		nxt.class_a.is_inf  = a_max & (fa == '0);
		nxt.class_a.is_qnan = a_max & fa[51];
		nxt.class_a.is_snan = a_max & (fa != '0) & ~fa[51];

		nxt.class_b.is_zero = (eb == '0);
		nxt.class_b.is_inf  = b_max & (fb == '0);
		nxt.class_b.is_qnan = b_max & fb[51];
		nxt.class_b.is_snan = b_max & (fb != '0) & ~fb[51];
	end

	always_ff @(posedge clk) begin
		unp <= nxt;
		if (rst)
			unp.valid <= 1'b0;
	end

endmodule

/* source/fpu_apb_regs.sv */
`timescale 1ns/100ps
`include "fpu_cfg.svh"

module fpu_apb_regs (
	input  logic              clk,
	input  logic              rst,
	input  logic              psel,
	input  logic              penable,
	input  logic              pwrite,
	input  logic [7:0]        paddr,
	input  logic [31:0]       pwdata,
	output logic [31:0]       prdata,
	output logic              pready,
	output logic              pslverr,
	output fpu_pkg::op_req_t  req,
	input  fpu_pkg::result_t  res
);
	import fpu_pkg::*;

	localparam int PTR_W = $clog2(`FPU_FIFO_DEPTH);
	localparam int CNT_W = $clog2(`FPU_FIFO_DEPTH + 1);

	fp64_t      opa_q;
	fp64_t      opb_q;
	rmode_t     rmode_q;
	result_t    mem [`FPU_FIFO_DEPTH];
	result_t    head;
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] fifo_cnt;
	logic [CNT_W-1:0] pending;   // in flight plus queued
	logic       access, wr, rd, addr_ok, ctrl_wr, full, empty, launch, pop;
	logic [31:0] rd_word;

	assign access  = psel & penable;
	assign wr      = access & pwrite;
	assign rd      = access & ~pwrite;
	assign ctrl_wr = wr & (paddr == `FPU_REG_CTRL);
	assign full    = (pending == CNT_W'(`FPU_FIFO_DEPTH));
	assign empty   = (fifo_cnt == '0);
	assign launch  = ctrl_wr & ~full;
	assign pop     = rd & (paddr == `FPU_REG_FLAGS) & ~empty;
	assign head    = mem[rd_ptr];

	assign pready  = 1'b1;
	assign pslverr = access & (~addr_ok | (ctrl_wr & full));
	assign prdata  = rd ? rd_word : '0;

	assign req.valid = launch;
	assign req.opa   = opa_q;
	assign req.opb   = opb_q;
	assign req.rmode = rmode_t'(pwdata[1:0]);

	always_comb begin
		addr_ok = 1'b1;
		rd_word = '0;
		case (paddr)
			`FPU_REG_OPA_LO: rd_word = opa_q[31:0];
			`FPU_REG_OPA_HI: rd_word = opa_q[63:32];
			`FPU_REG_OPB_LO: rd_word = opb_q[31:0];
			`FPU_REG_OPB_HI: rd_word = opb_q[63:32];
			`FPU_REG_CTRL:   rd_word = {30'b0, rmode_q};
			`FPU_REG_RES_LO: if (!empty) rd_word = head.value[31:0];
			`FPU_REG_RES_HI: if (!empty) rd_word = head.value[63:32];
			`FPU_REG_FLAGS:  if (!empty) rd_word = {23'b0, 1'b1, 3'b0, head.flags};
			default:         addr_ok = 1'b0;
		endcase
	end

	// ********************
	// operand registers

	always_ff @(posedge clk) begin
		if (rst) begin
			opa_q   <= '0;
			opb_q   <= '0;
			rmode_q <= '0;
		end else if (wr) begin
			case (paddr)
				`FPU_REG_OPA_LO: opa_q[31:0]  <= pwdata;
				`FPU_REG_OPA_HI: opa_q[63:32] <= pwdata;
				`FPU_REG_OPB_LO: opb_q[31:0]  <= pwdata;
				`FPU_REG_OPB_HI: opb_q[63:32] <= pwdata;
				`FPU_REG_CTRL:   rmode_q      <= rmode_t'(pwdata[1:0]);
				default: ;
			endcase
		end
	end

	// ********************
	// result fifo

	always_ff @(posedge clk) begin
		if (res.valid)
			mem[wr_ptr] <= res;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			fifo_cnt <= '0;
			pending  <= '0;
		end else begin
			if (res.valid)
				wr_ptr <= (wr_ptr == PTR_W'(`FPU_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == PTR_W'(`FPU_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({res.valid, pop})
				2'b10:   fifo_cnt <= fifo_cnt + 1'b1;
				2'b01:   fifo_cnt <= fifo_cnt - 1'b1;
				default: ;
			endcase
			case ({launch, pop})
				2'b10:   pending <= pending + 1'b1;
				2'b01:   pending <= pending - 1'b1;
				default: ;
			endcase
		end
	end

endmodule

/* source/fpu_pkg.sv */
package fpu_pkg;

	typedef logic [63:0] fp64_t;
	typedef logic signed [12:0] exp_t;   // biased, with headroom both ways
	typedef logic [52:0] mant_t;         // hidden bit included
	typedef logic [105:0] prod_t;
	typedef logic [1:0] rmode_t;         // 0 nearest even, 1 zero, 2 +inf, 3 -inf

	typedef struct packed {
		logic is_zero;
		logic is_inf;
		logic is_qnan;
		logic is_snan;
	} class_t;

	typedef struct packed {
		logic invalid;
		logic overflow;
		logic underflow;
		logic inexact;
		logic exception;
	} flags_t;

	typedef struct packed {
		logic   valid;
		fp64_t  opa;
		fp64_t  opb;
		rmode_t rmode;
	} op_req_t;

	// ********************
	// stage outputs

	typedef struct packed {
		logic       valid;
		rmode_t     rmode;
		fp64_t      opa;
		fp64_t      opb;
		logic [1:0] sign;   // {sign a, sign b}
		exp_t       exp_a;
		exp_t       exp_b;
		mant_t      mant_a;
		mant_t      mant_b;
		class_t     class_a;
		class_t     class_b;
	} unpacked_t;

	typedef struct packed {
		logic   valid;
		rmode_t rmode;
		logic   sign;
		exp_t   exp;
		prod_t  prod;
		fp64_t  opa;
		fp64_t  opb;
		class_t class_a;
		class_t class_b;
	} product_t;

	typedef struct packed {
		logic       valid;
		rmode_t     rmode;
		fp64_t      value;
		exp_t       exp_in;
		logic [1:0] lost;   // guard, sticky
		fp64_t      opa;
		fp64_t      opb;
		class_t     class_a;
		class_t     class_b;
	} rounded_t;

	typedef struct packed {
		logic   valid;
		fp64_t  value;
		flags_t flags;
	} result_t;

endpackage

/* include/fpu_cfg.svh */
`ifndef FPU_CFG_SVH
`define FPU_CFG_SVH

// APB register map
`define FPU_REG_OPA_LO 8'h00
`define FPU_REG_OPA_HI 8'h04
`define FPU_REG_OPB_LO 8'h08
`define FPU_REG_OPB_HI 8'h0C
`define FPU_REG_CTRL   8'h10   // rmode in [1:0], write launches
`define FPU_REG_RES_LO 8'h14
`define FPU_REG_RES_HI 8'h18
`define FPU_REG_FLAGS  8'h1C   // flags in [4:0], not empty in [8], read pops

`define FPU_FIFO_DEPTH 4
`define FPU_PIPE_DEPTH 5

`endif
